/* all.f */
mem_pkg.sv
mem_control.sv
mem_stage_reg.sv
mem_write_unit.sv
mem_stage.sv
tb_mem_stage.sv

/* mem_control.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_control
    import mem_pkg::*;
(
    input  word_t     pc,
    input  word_t     addr,
    input  inst_t     inst,
    output mem_ctrl_t ctrl
);

    logic [4:0] opcode5;
    logic [2:0] funct3;
    region_t    region;

    assign opcode5 = inst[6:2];
    assign funct3  = inst[14:12];
    assign region  = addr[31:28];

    // Mirror reads come from DMEM
    function automatic mem_sel_t load_sel(input region_t rgn);
        mem_sel_t sel;
        sel = '0;
        case (rgn)
            addr_io:     sel.io_en   = 1'b1;
            addr_bios:   sel.bios_en = 1'b1;
            addr_dmem:   sel.dmem_en = 1'b1;
            addr_mirror: sel.dmem_en = 1'b1;
            default:     sel = '0;
        endcase
        return sel;
    endfunction

    // IMEM is writable only while running from BIOS
    function automatic mem_sel_t store_sel(input region_t rgn, input logic pc_30);
        mem_sel_t sel;
        sel = '0;
        case (rgn)
            addr_io: begin
                sel.io_en = 1'b1;
            end
            addr_dmem: begin
                sel.dmem_en = 1'b1;
            end
            addr_imem: begin
                sel.imem_en = pc_30;
            end
            addr_mirror: begin
                sel.imem_en = pc_30;
                sel.dmem_en = 1'b1;
            end
            default: begin
                sel = '0;
            end
        endcase
        return sel;
    endfunction

    always_comb begin
        ctrl.sel     = '0;
        ctrl.din_sel = din_none;
        ctrl.size    = size_none;
        ctrl.br_inst = 1'b0;
        ctrl.bubble  = (inst == inst_nop);

        case (opcode5)
            opc_load, opc_fp_load: begin
                ctrl.sel = load_sel(region);
            end
            opc_store: begin
                ctrl.sel     = store_sel(region, pc[30]);
                ctrl.din_sel = din_rd2;
                case (funct3)
                    fnc_sb:  ctrl.size = size_byte;
                    fnc_sh:  ctrl.size = size_half;
                    fnc_sw:  ctrl.size = size_word;
                    default: ctrl.size = size_none;
                endcase
            end
            opc_fp_store: begin
                // FSW
                ctrl.sel     = store_sel(region, pc[30]);
                ctrl.din_sel = din_fpu;
                ctrl.size    = size_word;
            end
            opc_branch: begin
                case (funct3)
                    fnc_beq, fnc_bne, fnc_blt, fnc_bge, fnc_bltu, fnc_bgeu:
                        ctrl.br_inst = 1'b1;
                    default:
                        ctrl.br_inst = 1'b0;
                endcase
            end
            default: begin
                // No memory access
                ctrl.sel = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Meaningful widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  region_t;
    typedef logic [3:0]  byte_mask_t;
    typedef logic [29:0] word_addr_t;

    typedef enum logic [1:0] {
        size_none = 2'd0,
        size_byte = 2'd1,
        size_half = 2'd2,
        size_word = 2'd3
    } mem_size_t;

    typedef enum logic [1:0] {
        din_none = 2'd0,
        din_rd2  = 2'd1,
        din_fpu  = 2'd2
    } din_sel_t;

    // Opcode bits 6 to 2
    localparam logic [4:0] opc_load      = 5'b00000;
    localparam logic [4:0] opc_fp_load   = 5'b00001;
    localparam logic [4:0] opc_ari_itype = 5'b00100;
    localparam logic [4:0] opc_auipc     = 5'b00101;
    localparam logic [4:0] opc_store     = 5'b01000;
    localparam logic [4:0] opc_fp_store  = 5'b01001;
    localparam logic [4:0] opc_ari_rtype = 5'b01100;
    localparam logic [4:0] opc_lui       = 5'b01101;
    localparam logic [4:0] opc_fp_madd   = 5'b10000;
    localparam logic [4:0] opc_fp        = 5'b10100;
    localparam logic [4:0] opc_branch    = 5'b11000;
    localparam logic [4:0] opc_jalr      = 5'b11001;
    localparam logic [4:0] opc_jal       = 5'b11011;

    // Store funct3
    localparam logic [2:0] fnc_sb = 3'b000;
    localparam logic [2:0] fnc_sh = 3'b001;
    localparam logic [2:0] fnc_sw = 3'b010;

    // Branch funct3
    localparam logic [2:0] fnc_beq  = 3'b000;
    localparam logic [2:0] fnc_bne  = 3'b001;
    localparam logic [2:0] fnc_blt  = 3'b100;
    localparam logic [2:0] fnc_bge  = 3'b101;
    localparam logic [2:0] fnc_bltu = 3'b110;
    localparam logic [2:0] fnc_bgeu = 3'b111;

    // addi x0, x0, 0
    localparam inst_t inst_nop = 32'h0000_0013;

    // Address bits 31 to 28
    localparam region_t addr_dmem   = 4'h1;
    localparam region_t addr_imem   = 4'h2;
    localparam region_t addr_mirror = 4'h3;
    localparam region_t addr_bios   = 4'h4;
    localparam region_t addr_io     = 4'h8;

    typedef struct packed {
        logic imem_en;
        logic dmem_en;
        logic bios_en;
        logic io_en;
    } mem_sel_t;

    typedef struct packed {
        mem_sel_t  sel;
        din_sel_t  din_sel;
        mem_size_t size;
        logic      br_inst;
        logic      bubble;
    } mem_ctrl_t;

    typedef struct packed {
        mem_ctrl_t ctrl;
        word_t     addr;
        word_t     rd2_data;
        word_t     fpu_data;
    } ex_mem_t;

    typedef struct packed {
        mem_sel_t   sel;
        byte_mask_t we;
        word_t      wdata;
        word_addr_t waddr;
        logic       br_inst;
        logic       bubble;
    } mem_port_t;

    // Empty slot loaded on reset and flush
    localparam mem_ctrl_t ctrl_bubble = '{
        sel:     '0,
        din_sel: din_none,
        size:    size_none,
        br_inst: 1'b0,
        bubble:  1'b1
    };

    localparam ex_mem_t item_bubble = '{
        ctrl:     ctrl_bubble,
        addr:     '0,
        rd2_data: '0,
        fpu_data: '0
    };

endpackage

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  logic      flush,
    input  word_t     pc,
    input  word_t     addr,
    input  inst_t     inst,
    input  word_t     rd2_data,
    input  word_t     fpu_data,
    output mem_port_t mem_out
);

    mem_ctrl_t ctrl;
    ex_mem_t   ex_item;
    ex_mem_t   mem_item;

    mem_control u_ctrl (
        .pc   (pc),
        .addr (addr),
        .inst (inst),
        .ctrl (ctrl)
    );

    // Execute-side item with its store data
    assign ex_item = '{
        ctrl:     ctrl,
        addr:     addr,
        rd2_data: rd2_data,
        fpu_data: fpu_data
    };

    mem_stage_reg u_reg (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (flush),
        .d     (ex_item),
        .q     (mem_item)
    );

    mem_write_unit u_wr (
        .item (mem_item),
        .port (mem_out)
    );

endmodule

`default_nettype wire

/* mem_stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage_reg
    import mem_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  ex_mem_t d,
    output ex_mem_t q
);

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= item_bubble;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* mem_write_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_write_unit
    import mem_pkg::*;
(
    input  ex_mem_t   item,
    output mem_port_t port
);

    byte_mask_t base_mask;
    logic [6:0] wide_mask;
    word_t      store_data;

    // Unshifted mask from the store size
    always_comb begin
        case (item.ctrl.size)
            size_byte: base_mask = 4'b0001;
            size_half: base_mask = 4'b0011;
            size_word: base_mask = 4'b1111;
            default:   base_mask = 4'b0000;
        endcase
    end

    // Lanes past 3 fall off since misaligned accesses are not trapped
    assign wide_mask = {3'b000, base_mask} << item.addr[1:0];

    always_comb begin
        case (item.ctrl.din_sel)
            din_rd2: store_data = item.rd2_data;
            din_fpu: store_data = item.fpu_data;
            default: store_data = '0;
        endcase
    end

    always_comb begin
        port.sel     = item.ctrl.sel;
        port.we      = wide_mask[3:0];
        port.waddr   = item.addr[31:2];
        port.br_inst = item.ctrl.br_inst;
        port.bubble  = item.ctrl.bubble;

        // Replicate so every lane the mask can pick holds the data
        case (item.ctrl.size)
            size_byte: port.wdata = {4{store_data[7:0]}};
            size_half: port.wdata = {2{store_data[15:0]}};
            default:   port.wdata = store_data;
        endcase
    end

endmodule

`default_nettype wire

/* tb_mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage
    import mem_pkg::*;
();

    localparam int clk_period   = 8;
    localparam int reset_cycles = 8;
    localparam int n_random     = 2000;

    logic      clk;
    logic      reset;
    logic      stall;
    logic      flush;
    word_t     pc;
    word_t     addr;
    inst_t     inst;
    word_t     rd2_data;
    word_t     fpu_data;
    mem_port_t mem_out;

    integer    seed;
    int        errors;
    int        checks;
    mem_port_t exp_q;

    mem_stage UUT (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .flush    (flush),
        .pc       (pc),
        .addr     (addr),
        .inst     (inst),
        .rd2_data (rd2_data),
        .fpu_data (fpu_data),
        .mem_out  (mem_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((reset_cycles + n_random + 50) * clk_period);
        $display("Timeout: the stimulus did not complete in the expected time");
        $display("** FAIL **");
        $finish;
    end

    // Empty slot with everything zero but bubble
    function automatic mem_port_t bubble_port();
        mem_port_t p;
        p = '0;
        p.bubble = 1'b1;
        return p;
    endfunction

    function automatic inst_t make_inst(input logic [4:0] opc, input logic [2:0] f3);
        return {17'h0, f3, 5'h0, opc, 2'b11};
    endfunction

    // Reference decode of one execute-stage item into port signals
    function automatic mem_port_t expected_port(input word_t pc_v, input word_t addr_v,
                                                input inst_t inst_v, input word_t rd2_v,
                                                input word_t fpu_v);
        mem_port_t  p;
        logic [4:0] opc;
        logic [2:0] f3;
        region_t    rgn;
        int         nbytes;
        int         offset;
        word_t      src;
        opc    = inst_v[6:2];
        f3     = inst_v[14:12];
        rgn    = addr_v[31:28];
        p      = '0;
        nbytes = 0;
        src    = '0;
        p.waddr  = addr_v[31:2];
        p.bubble = (inst_v == inst_nop);
        if (opc == opc_load || opc == opc_fp_load) begin
            p.sel.io_en   = (rgn == addr_io);
            p.sel.bios_en = (rgn == addr_bios);
            p.sel.dmem_en = (rgn == addr_dmem) || (rgn == addr_mirror);
        end else if (opc == opc_store || opc == opc_fp_store) begin
            p.sel.io_en   = (rgn == addr_io);
            p.sel.dmem_en = (rgn == addr_dmem) || (rgn == addr_mirror);
            p.sel.imem_en = pc_v[30] && ((rgn == addr_imem) || (rgn == addr_mirror));
            if (opc == opc_fp_store) begin
                nbytes = 4;
                src    = fpu_v;
            end else begin
                src = rd2_v;
                if (f3 == fnc_sb)
                    nbytes = 1;
                else if (f3 == fnc_sh)
                    nbytes = 2;
                else if (f3 == fnc_sw)
                    nbytes = 4;
            end
        end else if (opc == opc_branch) begin
            p.br_inst = (f3 == fnc_beq) || (f3 == fnc_bne) || (f3 == fnc_blt) ||
                        (f3 == fnc_bge) || (f3 == fnc_bltu) || (f3 == fnc_bgeu);
        end
        // Lane k is written when it lies inside the access window
        offset = addr_v[1:0];
        for (int lane = 0; lane < 4; lane++) begin
            p.we[lane] = (lane >= offset) && (lane < offset + nbytes);
        end
        case (nbytes)
            1:       p.wdata = {4{src[7:0]}};
            2:       p.wdata = {2{src[15:0]}};
            default: p.wdata = src;
        endcase
        return p;
    endfunction

    task automatic random_inst(output inst_t inst_v);
        int         pick;
        logic [4:0] opc;
        word_t      raw;
        pick = {$random(seed)} % 14;
        raw  = $random(seed);
        case (pick)
            0:       opc = opc_load;
            1:       opc = opc_fp_load;
            2:       opc = opc_store;
            3:       opc = opc_fp_store;
            4:       opc = opc_branch;
            5:       opc = opc_ari_rtype;
            6:       opc = opc_ari_itype;
            7:       opc = opc_jal;
            8:       opc = opc_jalr;
            9:       opc = opc_lui;
            10:      opc = opc_auipc;
            11:      opc = opc_fp;
            default: opc = opc_fp_madd;
        endcase
        // Stores mostly pick a legal size
        if (opc == opc_store)
            raw[14] = 1'b0;
        raw[6:0] = {opc, 2'b11};
        if (pick == 13)
            inst_v = inst_nop;
        else
            inst_v = raw;
    endtask

    task automatic random_addr(output word_t addr_v);
        int    pick;
        word_t raw;
        raw  = $random(seed);
        pick = {$random(seed)} % 6;
        case (pick)
            0:       raw[31:28] = addr_dmem;
            1:       raw[31:28] = addr_imem;
            2:       raw[31:28] = addr_mirror;
            3:       raw[31:28] = addr_bios;
            4:       raw[31:28] = addr_io;
            default: raw[31:28] = raw[31:28];
        endcase
        addr_v = raw;
    endtask

    task check_sel(input string name, input mem_sel_t exp_v, input mem_sel_t act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    task check_mask(input string name, input byte_mask_t exp_v, input byte_mask_t act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    task check_word(input string name, input word_t exp_v, input word_t act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    task check_flag(input string name, input logic exp_v, input logic act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    task compare_port(input mem_port_t exp_p);
        check_sel("sel", exp_p.sel, mem_out.sel);
        check_mask("we", exp_p.we, mem_out.we);
        check_word("wdata", exp_p.wdata, mem_out.wdata);
        check_word("waddr", word_t'(exp_p.waddr), word_t'(mem_out.waddr));
        check_flag("br_inst", exp_p.br_inst, mem_out.br_inst);
        check_flag("bubble", exp_p.bubble, mem_out.bubble);
    endtask

    // Drive on the falling edge and check on the next one
    task apply_cycle(input word_t pc_v, input word_t addr_v, input inst_t inst_v,
                     input word_t rd2_v, input word_t fpu_v,
                     input logic stall_v, input logic flush_v);
        pc       = pc_v;
        addr     = addr_v;
        inst     = inst_v;
        rd2_data = rd2_v;
        fpu_data = fpu_v;
        stall    = stall_v;
        flush    = flush_v;
        if (flush_v)
            exp_q = bubble_port();
        else if (!stall_v)
            exp_q = expected_port(pc_v, addr_v, inst_v, rd2_v, fpu_v);
        @(negedge clk);
        compare_port(exp_q);
    endtask

    initial begin
        inst_t r_inst;
        word_t r_addr;
        word_t r_pc;
        word_t r_rd2;
        word_t r_fpu;
        logic  r_stall;
        logic  r_flush;
        seed     = 35;
        errors   = 0;
        checks   = 0;
        reset    = 1'b1;
        stall    = 1'b0;
        flush    = 1'b0;
        pc       = '0;
        addr     = '0;
        inst     = inst_nop;
        rd2_data = '0;
        fpu_data = '0;
        exp_q    = bubble_port();

        repeat (reset_cycles) @(negedge clk);
        compare_port(bubble_port());
        reset = 1'b0;

        apply_cycle(32'h4000_0000, 32'h1000_0100, make_inst(opc_store, fnc_sw),
                    32'hdead_beef, 32'h3f80_0000, 1'b0, 1'b0);
        // Stalled load must not replace the store
        apply_cycle(32'h0, 32'h8000_0000, make_inst(opc_load, 3'b010),
                    32'h0, 32'h0, 1'b1, 1'b0);
        apply_cycle(32'h0, 32'h8000_0000, make_inst(opc_load, 3'b010),
                    32'h0, 32'h0, 1'b1, 1'b1);
        // Half at offset 3 loses its upper byte
        apply_cycle(32'h0, 32'h3000_0043, make_inst(opc_store, fnc_sh),
                    32'h1234_5678, 32'h0, 1'b0, 1'b0);
        apply_cycle(32'h4000_0010, 32'h2000_0008, make_inst(opc_fp_store, 3'b010),
                    32'h0, 32'h4049_0fdb, 1'b0, 1'b0);
        apply_cycle(32'h0, 32'h0, make_inst(opc_branch, fnc_bltu),
                    32'h0, 32'h0, 1'b0, 1'b0);
        apply_cycle(32'h0, 32'h0, inst_nop, 32'h0, 32'h0, 1'b0, 1'b0);

        for (int i = 0; i < n_random; i++) begin
            random_inst(r_inst);
            random_addr(r_addr);
            r_pc    = $random(seed);
            r_rd2   = $random(seed);
            r_fpu   = $random(seed);
            r_stall = ({$random(seed)} % 10) == 0;
            r_flush = ({$random(seed)} % 10) == 0;
            apply_cycle(r_pc, r_addr, r_inst, r_rd2, r_fpu, r_stall, r_flush);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
